// ==== project.f ====
+incdir+include
src/melee_pkg.sv
src/frame_timer.sv
src/melee_wpn_animated.sv
src/pose_buffer.sv
src/weapon_renderer.sv
src/melee_top.sv
test/clk_gen.sv
test/melee_props.sv
test/tb_melee_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the melee_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    -f project.f \
    --top-module tb_melee_top \
    --Mdir obj_dir \
    -o tb_melee_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_output=$(./obj_dir/tb_melee_top_sim)
status=$?
printf '%s\n' "$sim_output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== test/tb_melee_top.sv ====
// Melee path testbench
`timescale 1ns/10ps
`include "melee_config.svh"

module tb_melee_top
    import melee_pkg::*;
();

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL; // Cycles per frame.
    localparam int RUN_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = (RUN_FRAMES + 5) * FRAME_CYCLES; // Room for reset and tail.
    localparam int ST_IDLE = 0, ST_FORWARD = 1, ST_BACKWARD = 2;

    logic    clk, rst, mouse_clicked, alive, move_left, move_right;
    logic    frame_tick, pixel_on;
    offset_t anim_x_offset;
    coord_t  player_x, pix_x, pix_y;

    int          err_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          last_tick_cycle = -1; // Cycle of the previous tick, none yet.
    int          hold_left;            // Frames until the click level flips.
    bit          check_en;

    // Reference model state.
    int h_m = 0, v_m = 0, st_m, cnt_m, tc_m, off_m, px_m, shown_m, pix_x_m, pix_y_m;
    bit clicked_d_m, pon_m;

    clk_gen u_clk_gen (.clk(clk));

    melee_top u_melee_top (
        .clk(clk), .rst(rst), .mouse_clicked(mouse_clicked), .alive(alive),
        .move_left(move_left), .move_right(move_right), .frame_tick(frame_tick),
        .anim_x_offset(anim_x_offset), .player_x(player_x), .pix_x(pix_x),
        .pix_y(pix_y), .pixel_on(pixel_on)
    );

    function automatic bit model_tick();
        return (h_m == `H_TOTAL - 1) && (v_m == `V_TOTAL - 1); // Last pixel of the frame.
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            err_count++;
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // One clock edge of the model, using the values from before the edge.
    task automatic update_model();
        bit tick;
        bit pulse;
        int left;
        tick    = model_tick();
        pulse   = mouse_clicked && !clicked_d_m; // Press seen against the last tick.
        left    = px_m + shown_m;                // Weapon left edge for this frame.
        pix_x_m = h_m;                           // Coordinates are delayed but never reset.
        pix_y_m = v_m;
        if (rst) begin
            h_m         = 0;
            v_m         = 0;
            st_m        = ST_IDLE;
            cnt_m       = 0;
            tc_m        = 0;
            off_m       = 0;
            px_m        = `PLAYER_X0;
            shown_m     = 0;
            clicked_d_m = 0;
            pon_m       = 0;
            return;
        end
        pon_m = (h_m >= left) && (h_m < left + `WPN_W) &&
                (v_m >= `WPN_Y) && (v_m < `WPN_Y + `WPN_H);
        if (h_m == 0 && v_m == 0) shown_m = off_m; // Frame start copy of the old offset.
        if (tick) begin
            if (move_left && !move_right) px_m = px_m - `PLAYER_STEP;
            if (move_right && !move_left) px_m = px_m + `PLAYER_STEP;
            if (px_m < 0) px_m = 0;                          // Left screen edge.
            if (px_m > `PLAYER_X_MAX) px_m = `PLAYER_X_MAX;  // Swing must fit on the right.
            clicked_d_m = mouse_clicked;
            if (alive) begin
                case (st_m)
                    ST_IDLE: begin
                        off_m = 0;
                        cnt_m = 0;
                        if (mouse_clicked) begin
                            st_m = ST_FORWARD;
                            tc_m = 0;
                        end
                    end
                    ST_FORWARD: begin
                        off_m = cnt_m; // Output shows the count from before the step.
                        if (pulse) begin
                            cnt_m = 0;
                            tc_m = 0;
                        end else if (tc_m < `SWING_WAIT) begin
                            tc_m++;
                        end else begin
                            tc_m = 0;
                            if (cnt_m + `SWING_STEP < `MAX_SWING) cnt_m += `SWING_STEP;
                            else st_m = ST_BACKWARD;
                        end
                    end
                    ST_BACKWARD: begin
                        off_m = cnt_m;
                        if (pulse) begin
                            cnt_m = 0;
                            tc_m = 0;
                            st_m = ST_FORWARD; // Restart on a fresh press.
                        end else if (tc_m < `SWING_WAIT) begin
                            tc_m++;
                        end else begin
                            tc_m = 0;
                            if (cnt_m > `SWING_STEP) begin
                                cnt_m -= `SWING_STEP;
                            end else begin
                                cnt_m = 0;
                                st_m = mouse_clicked ? ST_FORWARD : ST_IDLE; // Chain or rest.
                            end
                        end
                    end
                endcase
            end
        end
        if (h_m == `H_TOTAL - 1) begin
            h_m = 0;
            v_m = (v_m == `V_TOTAL - 1) ? 0 : v_m + 1; // Next line or new frame.
        end else begin
            h_m++;
        end
    endtask

    // Returns on the edge that ends the tick cycle.
    task automatic wait_for_tick();
        do @(negedge clk); while (frame_tick !== 1'b1);
        @(posedge clk);
    endtask

    // New input levels, held through the whole next frame.
    task automatic drive_random_inputs();
        if (hold_left == 0) begin
            mouse_clicked <= !mouse_clicked;      // Long holds chain swings.
            hold_left = $urandom_range(20, 2);
        end else begin
            hold_left--;
        end
        alive      <= ($urandom % 8) != 0;        // Dead now and then.
        move_left  <= 1'($urandom % 2);
        move_right <= 1'($urandom % 2);
    endtask

    always @(posedge clk) update_model();

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the frames", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // Outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (check_en) begin
            check_value("frame_tick", frame_tick, model_tick());
            check_value("anim_x_offset", int'(anim_x_offset), off_m);
            check_value("player_x", int'(player_x), px_m);
            check_value("pix_x", int'(pix_x), pix_x_m);
            check_value("pix_y", int'(pix_y), pix_y_m);
            check_value("pixel_on", pixel_on, pon_m);
            if (frame_tick === 1'b1) begin
                if (last_tick_cycle >= 0) begin
                    check_value("frame_tick interval", cycle_count - last_tick_cycle,
                                FRAME_CYCLES);
                end
                last_tick_cycle = cycle_count;
            end
        end
    end

    initial begin
        rst           = 1'b1;
        mouse_clicked = 1'b0;
        alive         = 1'b1;
        move_left     = 1'b0;
        move_right    = 1'b0;
        check_en      = 1'b0;
        hold_left     = 0;
        void'($urandom(35)); // Seeds the generator once.
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_en = 1'b1;
        for (int f = 0; f < RUN_FRAMES; f++) begin
            wait_for_tick();
            drive_random_inputs();
        end
        wait_for_tick(); // Let the last frame draw with the last pose.
        @(posedge clk);  // The falling edge check in between has run by now.
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== test/melee_props.sv ====
// Melee path assertions
`timescale 1ns/10ps

module melee_props
    import melee_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        frame_tick,
    input offset_t     shown_offset,
    input anim_state_t anim_state
);

    // A frame is far longer than one cycle, so ticks never touch.
    no_double_tick: assert property (@(posedge clk) disable iff (rst)
        frame_tick |=> !frame_tick)
        else $error("frame_tick was high on two consecutive cycles");

    // The copy is taken on the edge that ends the first pixel, one cycle after the tick.
    offset_frame_stable: assert property (@(posedge clk) disable iff (rst)
        $changed(shown_offset) |-> $past(frame_tick, 2))
        else $error("shown_offset changed away from the frame start");

    // Only three states exist, so the fourth encoding must never show up.
    state_legal: assert property (@(posedge clk) disable iff (rst)
        2'(anim_state) != 2'b11)
        else $error("animator state took the unused encoding");

endmodule

// The swing state is reached through the animator instance.
bind melee_top melee_props u_melee_props (
    .clk          (clk),
    .rst          (rst),
    .frame_tick   (frame_tick),
    .shown_offset (shown_offset),
    .anim_state   (u_melee_wpn_animated.anim_state)
);

// ==== test/clk_gen.sv ====
// Testbench clock source
`timescale 1ns/10ps

module clk_gen (
    output logic clk
);

    localparam realtime HALF_PERIOD = 4.0; // Gives the 8 ns period.

    initial begin
        clk = 1'b0; // Known level before the first edge.
    end

    // Free running clock for the whole run.
    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// ==== src/melee_top.sv ====
// Melee weapon video path
`timescale 1ns/10ps

module melee_top
    import melee_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    mouse_clicked,
    input  logic    alive,
    input  logic    move_left,
    input  logic    move_right,
    output logic    frame_tick,
    output offset_t anim_x_offset,
    output coord_t  player_x,
    output coord_t  pix_x,
    output coord_t  pix_y,
    output logic    pixel_on
);

    coord_t  hcount;       // Raster column.
    coord_t  vcount;       // Raster line.
    offset_t shown_offset; // Offset frozen for the current frame.

    // Raster sweep and per frame tick.
    frame_timer u_frame_timer (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .frame_tick (frame_tick)
    );

    // Swing animation, one step per tick.
    melee_wpn_animated u_melee_wpn_animated (
        .clk           (clk),
        .rst           (rst),
        .frame_tick    (frame_tick),
        .mouse_clicked (mouse_clicked),
        .alive         (alive),
        .anim_x_offset (anim_x_offset)
    );

    // Player position and the frame stable offset.
    pose_buffer u_pose_buffer (
        .clk           (clk),
        .rst           (rst),
        .frame_tick    (frame_tick),
        .move_left     (move_left),
        .move_right    (move_right),
        .hcount        (hcount),
        .vcount        (vcount),
        .anim_x_offset (anim_x_offset),
        .player_x      (player_x),
        .shown_offset  (shown_offset)
    );

    // Per pixel weapon test.
    weapon_renderer u_weapon_renderer (
        .clk          (clk),
        .rst          (rst),
        .hcount       (hcount),
        .vcount       (vcount),
        .player_x     (player_x),
        .shown_offset (shown_offset),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pixel_on     (pixel_on)
    );

endmodule

// ==== src/weapon_renderer.sv ====
// Weapon rectangle renderer
`timescale 1ns/10ps
`include "melee_config.svh"

module weapon_renderer
    import melee_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  coord_t  hcount,
    input  coord_t  vcount,
    input  coord_t  player_x,
    input  offset_t shown_offset,
    output coord_t  pix_x,
    output coord_t  pix_y,
    output logic    pixel_on
);

    logic signed [13:0] hx;       // Current pixel column, signed.
    logic signed [13:0] vy;       // Current pixel line, signed.
    logic signed [13:0] px;       // Player column, signed.
    logic signed [13:0] off;      // Swing offset, sign extended.
    logic signed [13:0] wpn_left; // Left edge of the weapon.
    logic               in_x;     // Column lies inside the weapon.
    logic               in_y;     // Line lies inside the weapon.

    // Widen everything by two bits so the sum and compares cannot wrap.
    assign hx  = $signed({2'b00, hcount});
    assign vy  = $signed({2'b00, vcount});
    assign px  = $signed({2'b00, player_x});
    assign off = shown_offset; // Signed source, so this sign extends.

    assign wpn_left = px + off; // Weapon sits at the player plus the swing.

    // Half open ranges, WPN_W columns and WPN_H lines.
    assign in_x = (hx >= wpn_left) && (hx < wpn_left + 14'sd`WPN_W);
    assign in_y = (vy >= 14'sd`WPN_Y) && (vy < 14'sd`WPN_Y + 14'sd`WPN_H);

    // Coordinates travel with the flag, so the outputs stay aligned.
    always_ff @(posedge clk) begin
        pix_x <= hcount;
        pix_y <= vcount;
    end

    // One cycle of latency on the hit flag.
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_on <= 1'b0;
        end else begin
            pixel_on <= in_x && in_y; // Inside on both axes.
        end
    end

endmodule

// ==== src/pose_buffer.sv ====
// Player pose buffer
`timescale 1ns/10ps
`include "melee_config.svh"

module pose_buffer
    import melee_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    frame_tick,
    input  logic    move_left,
    input  logic    move_right,
    input  coord_t  hcount,
    input  coord_t  vcount,
    input  offset_t anim_x_offset,
    output coord_t  player_x,
    output offset_t shown_offset
);

    logic   left_only;   // Only the left key is held.
    logic   right_only;  // Only the right key is held.
    logic   frame_start; // Raster is on the first pixel of a frame.
    coord_t x_moved;     // Position after the step, before clamping.
    coord_t x_next;      // Clamped position for the next frame.

    assign left_only   = move_left && !move_right;
    assign right_only  = move_right && !move_left; // Both held cancel out.
    assign frame_start = (hcount == '0) && (vcount == '0);

    // Step the position, saturating at zero on the left.
    always_comb begin
        if (left_only) begin
            if (player_x > coord_t'(`PLAYER_STEP)) begin
                x_moved = player_x - coord_t'(`PLAYER_STEP);
            end else begin
                x_moved = '0; // Would pass the left edge.
            end
        end else if (right_only) begin
            x_moved = player_x + coord_t'(`PLAYER_STEP);
        end else begin
            x_moved = player_x; // No move this frame.
        end
        // Right clamp keeps the whole swing on screen.
        if (x_moved > coord_t'(`PLAYER_X_MAX)) begin
            x_next = coord_t'(`PLAYER_X_MAX);
        end else begin
            x_next = x_moved;
        end
    end

    // Position updates once per frame. The clamp also applies to a reset value out of range.
    always_ff @(posedge clk) begin
        if (rst) begin
            player_x <= coord_t'(`PLAYER_X0);
        end else if (frame_tick) begin
            player_x <= x_next;
        end
    end

    // Freeze the swing offset at frame start, so a step never tears a frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            shown_offset <= '0;
        end else if (frame_start) begin
            shown_offset <= anim_x_offset; // Held for the whole frame.
        end
    end

endmodule

// ==== src/melee_wpn_animated.sv ====
// Melee weapon swing animator
`timescale 1ns/10ps
`include "melee_config.svh"

module melee_wpn_animated
    import melee_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    frame_tick,
    input  logic    mouse_clicked,
    input  logic    alive,
    output offset_t anim_x_offset
);

    anim_state_t anim_state;      // Swing state.
    logic [11:0] anim_count;      // Current swing distance.
    logic [7:0]  tick_count;      // Ticks held since the last step.
    logic        mouse_clicked_d; // Click level seen at the previous tick.
    logic        mouse_click_pulse;

    // Sample the click once per frame so edges are seen at tick rate.
    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_clicked_d <= 1'b0;
        end else if (frame_tick) begin
            mouse_clicked_d <= mouse_clicked; // Level for the next edge test.
        end
    end

    assign mouse_click_pulse = mouse_clicked && !mouse_clicked_d; // New press this tick.

    // Swing FSM. Everything moves only on a tick while the player lives.
    always_ff @(posedge clk) begin
        if (rst) begin
            anim_state    <= IDLE;
            anim_count    <= '0;
            tick_count    <= '0;
            anim_x_offset <= '0;
        end else if (frame_tick && alive) begin
            case (anim_state)
                IDLE: begin
                    anim_x_offset <= '0; // Weapon at rest.
                    anim_count    <= '0;
                    if (mouse_clicked) begin
                        anim_state <= FORWARD; // A held click starts a swing.
                        tick_count <= '0;
                    end
                end

                FORWARD: begin
                    if (mouse_click_pulse) begin
                        anim_count <= '0; // Fresh press restarts the swing.
                        tick_count <= '0;
                    end else if (tick_count < 8'(`SWING_WAIT)) begin
                        tick_count <= tick_count + 8'd1; // Hold this step.
                    end else begin
                        tick_count <= '0;
                        if (anim_count + 12'(`SWING_STEP) < 12'(`MAX_SWING)) begin
                            anim_count <= anim_count + 12'(`SWING_STEP); // Reach further.
                        end else begin
                            anim_state <= BACKWARD; // Limit reached, turn around.
                        end
                    end
                    anim_x_offset <= offset_t'(anim_count); // Count from before this edge.
                end

                BACKWARD: begin
                    if (mouse_click_pulse) begin
                        anim_count <= '0; // Fresh press restarts the swing.
                        tick_count <= '0;
                        anim_state <= FORWARD;
                    end else if (tick_count < 8'(`SWING_WAIT)) begin
                        tick_count <= tick_count + 8'd1;
                    end else begin
                        tick_count <= '0;
                        if (anim_count > 12'(`SWING_STEP)) begin
                            anim_count <= anim_count - 12'(`SWING_STEP); // Pull back.
                        end else begin
                            anim_count <= '0; // Home again.
                            if (mouse_clicked) begin
                                anim_state <= FORWARD; // Held click chains another swing.
                            end else begin
                                anim_state <= IDLE;
                            end
                        end
                    end
                    anim_x_offset <= offset_t'(anim_count);
                end

                default: begin
                    anim_state <= IDLE; // Recover from the unused encoding.
                end
            endcase
        end
    end

endmodule

// ==== src/frame_timer.sv ====
// Raster frame timer
`timescale 1ns/10ps
`include "melee_config.svh"

module frame_timer
    import melee_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output coord_t hcount,
    output coord_t vcount,
    output logic   frame_tick
);

    logic line_end;  // Last pixel of the current line.
    logic frame_end; // Last line of the frame.
    logic tick_next; // Next cycle is the last pixel of the frame.

    assign line_end  = (hcount == coord_t'(`H_TOTAL - 1)); // Wrap point of hcount.
    assign frame_end = (vcount == coord_t'(`V_TOTAL - 1)); // Wrap point of vcount.

    // The tick is registered, so it is decoded one pixel early.
    assign tick_next = (hcount == coord_t'(`H_TOTAL - 2)) && frame_end;

    // Pixel counter, one step per clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0; // Start at the top left pixel.
        end else if (line_end) begin
            hcount <= '0; // Back to the start of the next line.
        end else begin
            hcount <= hcount + coord_t'(1); // Next pixel.
        end
    end

    // Line counter, steps at the end of every line.
    always_ff @(posedge clk) begin
        if (rst) begin
            vcount <= '0; // First line.
        end else if (line_end) begin
            if (frame_end) begin
                vcount <= '0; // New frame starts at line zero.
            end else begin
                vcount <= vcount + coord_t'(1); // Next line.
            end
        end
    end

    // Frame tick, high only while the last pixel of the frame is on the raster.
    // This paces every game update at one per frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_tick <= 1'b0; // No tick during reset.
        end else begin
            frame_tick <= tick_next; // Aligned with hcount and vcount at the last pixel.
        end
    end

endmodule

// ==== src/melee_pkg.sv ====
// Melee game types
package melee_pkg;

    // Swing animator states. The fourth encoding is never used.
    typedef enum logic [1:0] {
        IDLE,     // Weapon at rest.
        FORWARD,  // Swing moving out.
        BACKWARD  // Swing returning.
    } anim_state_t;

    // Unsigned screen coordinate, wide enough for any raster we use.
    typedef logic [11:0] coord_t;

    // Signed horizontal swing offset in pixels.
    typedef logic signed [11:0] offset_t;

endpackage

// ==== include/melee_config.svh ====
// Melee weapon configuration
`ifndef MELEE_CONFIG_SVH
`define MELEE_CONFIG_SVH

// Raster size in pixels. The whole raster is visible.
`define H_TOTAL 40 // Pixels per line.
`define V_TOTAL 30 // Lines per frame.

// Swing animation constants.
`define MAX_SWING  45 // Forward limit of the swing count.
`define SWING_STEP 10 // Count change per swing step.
`define SWING_WAIT 2  // Frame ticks held before each step.

// Weapon rectangle.
`define WPN_W 6  // Width in pixels.
`define WPN_H 4  // Height in pixels.
`define WPN_Y 20 // Top line of the rectangle.

// Player movement.
`define PLAYER_STEP 1 // Pixels moved per frame tick.
`define PLAYER_X0   5 // Position after reset.

// Largest player position that still fits the full swing on screen.
// H_TOTAL - WPN_W - MAX_SWING is negative for this raster, so it clamps to 0.
`define PLAYER_X_MAX 0

`endif
